// File: design/load_path_pkg.sv
package load_path_pkg;

  // data and address width
  localparam int XLEN = 32;

  // reorder index width, 8 reorder entries
  // structs carry this, so it stays fixed
  localparam int ROB_IX_W = 3;

  // load opcodes, funct3 order is not kept
  typedef enum logic [2:0] {
    LOP_LB,
    LOP_LH,
    LOP_LW,
    LOP_LBU,
    LOP_LHU
  } load_op_e;

  // request into the address generator
  typedef struct packed {
    load_op_e                   op;
    logic [XLEN-1:0]            base;
    // immediate, sign kept for the add
    logic signed [XLEN-1:0]     offset;
    logic [ROB_IX_W-1:0]        rob_ix;
  } load_req_t;

  // one buffer row, also the issue payload
  typedef struct packed {
    load_op_e                   op;
    logic [XLEN-1:0]            addr;
    logic [ROB_IX_W-1:0]        rob_ix;
  } load_entry_t;

  // result toward the common data bus
  typedef struct packed {
    logic [ROB_IX_W-1:0]        rob_ix;
    logic [XLEN-1:0]            data;
    logic                       misaligned;
  } load_result_t;

endpackage

// File: design/load_addr_gen.sv
`timescale 1ns/1ps

module load_addr_gen (
  input  logic                       clk_in,
  input  logic                       rst_n,
  input  logic                       flush,

  // request side
  input  load_path_pkg::load_req_t   req,
  input  logic                       req_valid,
  output logic                       req_ready,

  // toward the load buffer
  output load_path_pkg::load_entry_t entry,
  output logic                       entry_valid,
  input  logic                       entry_ready
);

  // effective address of the incoming request
  logic [load_path_pkg::XLEN-1:0] eff_addr;
  // request taken on this edge
  logic                           req_fire;

  // base plus sign-extended offset, wraps at 32 bits
  always_comb begin
    eff_addr = req.base + req.offset;
  end

  // slot free, or being drained this cycle
  assign req_ready = !entry_valid || entry_ready;
  assign req_fire  = req_valid && req_ready;

  // slot valid bit
  always_ff @(posedge clk_in) begin
    if (!rst_n || flush) begin
      entry_valid <= 1'b0;
    end else if (req_ready) begin
      // refill in the same cycle it drains
      entry_valid <= req_valid;
    end
  end

  // slot payload, only loaded on a transfer
  always_ff @(posedge clk_in) begin
    if (req_fire) begin
      entry.op     <= req.op;
      entry.addr   <= eff_addr;
      entry.rob_ix <= req.rob_ix;
    end
  end

  // held entry must not move until the buffer takes it
  property p_entry_hold;
    @(posedge clk_in) disable iff (!rst_n || flush)
      entry_valid && !entry_ready |=> entry_valid && $stable(entry);
  endproperty

  a_entry_hold : assert property (p_entry_hold)
    else $error("load_addr_gen: entry changed while stalled");

endmodule

// File: design/load_buffer.sv
`timescale 1ns/1ps

module load_buffer #(
  parameter int LB_DEPTH = 4
) (
  input  logic                                        clk_in,
  input  logic                                        rst_n,
  input  logic                                        flush,

  // from the address generator
  input  load_path_pkg::load_entry_t                  entry,
  input  logic                                        entry_valid,
  output logic                                        entry_ready,

  // ordering check
  output logic [LB_DEPTH*load_path_pkg::ROB_IX_W-1:0] row_rob_ix,
  input  logic [LB_DEPTH-1:0]                         can_load,

  // toward the memory unit
  output load_path_pkg::load_entry_t                  issue,
  output logic                                        issue_valid,
  input  logic                                        issue_ready
);

  // row index width, at least one bit
  localparam int IX_W = (LB_DEPTH > 1) ? $clog2(LB_DEPTH) : 1;

  load_path_pkg::load_entry_t rows [LB_DEPTH];
  logic [LB_DEPTH-1:0]        occupied;
  // occupied and cleared by the ordering check
  logic [LB_DEPTH-1:0]        eligible;
  logic [IX_W-1:0]            free_row;
  logic [IX_W-1:0]            issue_row;
  logic                       wr_en;
  logic                       rd_en;

  // flat export of every row's reorder index
  always_comb begin
    for (int i = 0; i < LB_DEPTH; i++) begin
      row_rob_ix[i*load_path_pkg::ROB_IX_W +: load_path_pkg::ROB_IX_W] = rows[i].rob_ix;
    end
  end

  // lowest free row, scan down so the lowest wins
  always_comb begin
    free_row = '0;
    for (int i = LB_DEPTH - 1; i >= 0; i--) begin
      if (!occupied[i]) begin
        free_row = IX_W'(i);
      end
    end
  end

  // highest eligible row, scan up so the highest wins
  always_comb begin
    issue_row = '0;
    for (int i = 0; i < LB_DEPTH; i++) begin
      if (eligible[i]) begin
        issue_row = IX_W'(i);
      end
    end
  end

  assign eligible    = can_load & occupied;
  assign entry_ready = !(&occupied);
  assign issue_valid = |eligible;
  assign issue       = rows[issue_row];

  assign wr_en = entry_valid && entry_ready;
  assign rd_en = issue_valid && issue_ready;

  // occupancy, fill and free can share a cycle
  // they never hit the same row since the free row is empty
  always_ff @(posedge clk_in) begin
    if (!rst_n || flush) begin
      occupied <= '0;
    end else begin
      if (wr_en) begin
        occupied[free_row] <= 1'b1;
      end
      if (rd_en) begin
        occupied[issue_row] <= 1'b0;
      end
    end
  end

  // row payload
  always_ff @(posedge clk_in) begin
    if (wr_en) begin
      rows[free_row] <= entry;
    end
  end

  // write lands in an empty row and sticks there
  property p_write_free;
    @(posedge clk_in) disable iff (!rst_n || flush)
      wr_en |-> !occupied[free_row] ##1 occupied[$past(free_row)];
  endproperty

  a_write_free : assert property (p_write_free)
    else $error("load_buffer: write while full or into a busy row");

  // no issue out of an empty row
  property p_issue_occupied;
    @(posedge clk_in) disable iff (!rst_n || flush)
      issue_valid |-> occupied[issue_row] && can_load[issue_row];
  endproperty

  a_issue_occupied : assert property (p_issue_occupied)
    else $error("load_buffer: issue from an empty row");

endmodule

// File: design/load_order_check.sv
`timescale 1ns/1ps

module load_order_check #(
  parameter int LB_DEPTH = 4
) (
  // reorder index of every buffer row
  input  logic [LB_DEPTH*load_path_pkg::ROB_IX_W-1:0] row_rob_ix,

  // reorder head and the oldest unresolved store
  input  logic [load_path_pkg::ROB_IX_W-1:0]          rob_head,
  input  logic                                        barrier_valid,
  input  logic [load_path_pkg::ROB_IX_W-1:0]          barrier_ix,

  // per row issue permission, occupancy not looked at
  output logic [LB_DEPTH-1:0]                         can_load
);

  // age of the barrier store, distance from the head
  logic [load_path_pkg::ROB_IX_W-1:0] barrier_age;
  // age of each row, same measure
  logic [load_path_pkg::ROB_IX_W-1:0] row_age [LB_DEPTH];

  // subtraction truncated to the index width
  // gives the modulo 8 distance, so wraparound needs nothing extra
  always_comb begin
    barrier_age = barrier_ix - rob_head;
  end

  always_comb begin
    for (int i = 0; i < LB_DEPTH; i++) begin
      row_age[i] = row_rob_ix[i*load_path_pkg::ROB_IX_W +: load_path_pkg::ROB_IX_W]
                   - rob_head;
    end
  end

  // no barrier means every row may go
  // otherwise only loads strictly older than the store
  // equal age is the store slot itself, held back
  always_comb begin
    for (int i = 0; i < LB_DEPTH; i++) begin
      can_load[i] = !barrier_valid || (row_age[i] < barrier_age);
    end
  end

endmodule

// File: design/load_mem_unit.sv
`timescale 1ns/1ps

module load_mem_unit #(
  parameter int MEM_WORDS = 256
) (
  input  logic                              clk_in,
  input  logic                              rst_n,
  input  logic                              flush,

  // issue from the load buffer
  input  load_path_pkg::load_entry_t        issue,
  input  logic                              issue_valid,
  output logic                              issue_ready,

  // result toward the bus
  output load_path_pkg::load_result_t       result,
  output logic                              result_valid,
  input  logic                              result_ready,

  // plain write port, stands in for store commit
  input  logic                              mem_we,
  input  logic [$clog2(MEM_WORDS)-1:0]      mem_waddr,
  input  logic [load_path_pkg::XLEN-1:0]    mem_wdata
);

  localparam int XLEN = load_path_pkg::XLEN;

  logic [XLEN-1:0]            mem [MEM_WORDS];

  // stage 1, address and opcode
  logic                       s1_valid;
  load_path_pkg::load_entry_t s1_entry;
  // word index, wraps modulo depth
  logic [XLEN-1:0]            s1_widx;

  // stage 2, fetched word
  logic                       s2_valid;
  load_path_pkg::load_op_e    s2_op;
  logic [1:0]                 s2_off;
  logic [load_path_pkg::ROB_IX_W-1:0] s2_rob_ix;
  logic [XLEN-1:0]            s2_word;

  // extraction
  logic [7:0]                 sel_byte;
  logic [15:0]                sel_half;
  logic                       stall;

  // whole pipe freezes when the result is not taken
  assign stall       = s2_valid && !result_ready;
  assign issue_ready = !stall;

  assign s1_widx = (s1_entry.addr >> 2) % MEM_WORDS;

  // data memory, cleared on reset
  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (mem_we) begin
      mem[mem_waddr] <= mem_wdata;
    end
  end

  // valid bits
  always_ff @(posedge clk_in) begin
    if (!rst_n || flush) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else if (!stall) begin
      s1_valid <= issue_valid;
      s2_valid <= s1_valid;
    end
  end

  // payload of both stages
  always_ff @(posedge clk_in) begin
    if (!stall) begin
      s1_entry  <= issue;
      s2_op     <= s1_entry.op;
      s2_off    <= s1_entry.addr[1:0];
      s2_rob_ix <= s1_entry.rob_ix;
      s2_word   <= mem[s1_widx];
    end
  end

  // little endian lane select
  assign sel_byte = s2_word[8*s2_off +: 8];
  assign sel_half = s2_word[16*s2_off[1] +: 16];

  // extend by opcode, misaligned returns zero data
  always_comb begin
    result.rob_ix     = s2_rob_ix;
    result.misaligned = 1'b0;
    result.data       = '0;
    case (s2_op)
      load_path_pkg::LOP_LB:  result.data = {{(XLEN-8){sel_byte[7]}}, sel_byte};
      load_path_pkg::LOP_LBU: result.data = {{(XLEN-8){1'b0}}, sel_byte};
      load_path_pkg::LOP_LH,
      load_path_pkg::LOP_LHU: begin
        result.misaligned = s2_off[0];
        if (!s2_off[0]) begin
          result.data = (s2_op == load_path_pkg::LOP_LH) ?
                        {{(XLEN-16){sel_half[15]}}, sel_half} :
                        {{(XLEN-16){1'b0}}, sel_half};
        end
      end
      load_path_pkg::LOP_LW: begin
        result.misaligned = (s2_off != 2'b00);
        if (s2_off == 2'b00) begin
          result.data = s2_word;
        end
      end
      // unused encodings hand back the raw word
      default: result.data = s2_word;
    endcase
  end

  assign result_valid = s2_valid;

  // stalled result holds still until taken
  property p_result_hold;
    @(posedge clk_in) disable iff (!rst_n || flush)
      result_valid && !result_ready |=> result_valid && $stable(result);
  endproperty

  a_result_hold : assert property (p_result_hold)
    else $error("load_mem_unit: result changed while stalled");

endmodule

// File: design/load_path_top.sv
`timescale 1ns/1ps

module load_path_top #(
  parameter int LB_DEPTH  = 4,
  parameter int MEM_WORDS = 256
) (
  input  logic                                clk_in,
  input  logic                                rst_n,
  input  logic                                flush,

  // load requests
  input  load_path_pkg::load_req_t            req,
  input  logic                                req_valid,
  output logic                                req_ready,

  // ordering state from the reorder buffer
  input  logic [load_path_pkg::ROB_IX_W-1:0]  rob_head,
  input  logic                                barrier_valid,
  input  logic [load_path_pkg::ROB_IX_W-1:0]  barrier_ix,

  // results
  output load_path_pkg::load_result_t         result,
  output logic                                result_valid,
  input  logic                                result_ready,

  // store commit stand-in
  input  logic                                mem_we,
  input  logic [$clog2(MEM_WORDS)-1:0]        mem_waddr,
  input  logic [load_path_pkg::XLEN-1:0]      mem_wdata
);

  // generator to buffer
  load_path_pkg::load_entry_t                  entry;
  logic                                        entry_valid;
  logic                                        entry_ready;

  // buffer and ordering check
  logic [LB_DEPTH*load_path_pkg::ROB_IX_W-1:0] row_rob_ix;
  logic [LB_DEPTH-1:0]                         can_load;

  // buffer to memory unit
  load_path_pkg::load_entry_t                  issue;
  logic                                        issue_valid;
  logic                                        issue_ready;

  load_addr_gen load_addr_gen_i (
    .clk_in      (clk_in),
    .rst_n       (rst_n),
    .flush       (flush),
    .req         (req),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .entry       (entry),
    .entry_valid (entry_valid),
    .entry_ready (entry_ready)
  );

  load_buffer #(
    .LB_DEPTH (LB_DEPTH)
  ) load_buffer_i (
    .clk_in      (clk_in),
    .rst_n       (rst_n),
    .flush       (flush),
    .entry       (entry),
    .entry_valid (entry_valid),
    .entry_ready (entry_ready),
    .row_rob_ix  (row_rob_ix),
    .can_load    (can_load),
    .issue       (issue),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready)
  );

  // combinational, sits beside the buffer
  load_order_check #(
    .LB_DEPTH (LB_DEPTH)
  ) load_order_check_i (
    .row_rob_ix    (row_rob_ix),
    .rob_head      (rob_head),
    .barrier_valid (barrier_valid),
    .barrier_ix    (barrier_ix),
    .can_load      (can_load)
  );

  load_mem_unit #(
    .MEM_WORDS (MEM_WORDS)
  ) load_mem_unit_i (
    .clk_in       (clk_in),
    .rst_n        (rst_n),
    .flush        (flush),
    .issue        (issue),
    .issue_valid  (issue_valid),
    .issue_ready  (issue_ready),
    .result       (result),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .mem_we       (mem_we),
    .mem_waddr    (mem_waddr),
    .mem_wdata    (mem_wdata)
  );

endmodule

// File: verification/load_path_tb.sv
`timescale 1ns/1ps

module load_path_tb;

  localparam int LB_DEPTH  = 4;
  localparam int MEM_WORDS = 256;
  localparam int MA_W      = $clog2(MEM_WORDS);
  localparam int N_IX      = 1 << load_path_pkg::ROB_IX_W;

  // loads per test, sizes the watchdog
  localparam int N_EXT   = 80;
  localparam int N_MIS   = 11;
  localparam int N_BAR   = 6;
  localparam int N_BP    = 8;
  localparam int N_FL    = 8;
  localparam int N_RAND  = 100;
  localparam int N_LOADS = N_EXT + N_MIS + N_BAR + N_BP + N_FL + N_RAND;
  localparam int WATCHDOG_CYCLES = 200 * N_LOADS + 1000;

  logic                                clk_in = 1'b0;
  logic                                rst_n;
  logic                                flush;
  load_path_pkg::load_req_t            req;
  logic                                req_valid;
  logic                                req_ready;
  logic [load_path_pkg::ROB_IX_W-1:0]  rob_head;
  logic                                barrier_valid;
  logic [load_path_pkg::ROB_IX_W-1:0]  barrier_ix;
  load_path_pkg::load_result_t         result;
  logic                                result_valid;
  logic                                result_ready;
  logic                                mem_we;
  logic [MA_W-1:0]                     mem_waddr;
  logic [31:0]                         mem_wdata;

  // memory model and scoreboard, indexed by rob_ix
  logic [31:0]                         mem_model [MEM_WORDS];
  load_path_pkg::load_result_t         exp_res [N_IX];
  logic [N_IX-1:0]                     pending = '0;

  int                                  err_count = 0;
  int                                  tests_ok = 0;
  int                                  tests_bad = 0;
  // barrier test only, younger results are errors
  bit                                  check_barrier = 1'b0;
  bit                                  prev_stalled = 1'b0;
  load_path_pkg::load_result_t         prev_result;

  load_path_top #(
    .LB_DEPTH  (LB_DEPTH),
    .MEM_WORDS (MEM_WORDS)
  ) load_path_top_i (
    .clk_in        (clk_in),
    .rst_n         (rst_n),
    .flush         (flush),
    .req           (req),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .rob_head      (rob_head),
    .barrier_valid (barrier_valid),
    .barrier_ix    (barrier_ix),
    .result        (result),
    .result_valid  (result_valid),
    .result_ready  (result_ready),
    .mem_we        (mem_we),
    .mem_waddr     (mem_waddr),
    .mem_wdata     (mem_wdata)
  );

  // 4 ns period
  always #2 clk_in = ~clk_in;

  // expected result from address, opcode and memory image
  function automatic load_path_pkg::load_result_t ref_load(
    input load_path_pkg::load_op_e op,
    input logic [31:0]             base,
    input logic [31:0]             offset,
    input logic [2:0]              rob_ix,
    input logic [31:0]             img [MEM_WORDS]
  );
    load_path_pkg::load_result_t r;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] lane;
    addr = base + offset;
    word = img[(addr >> 2) % MEM_WORDS];
    // addressed lane shifted down to bit 0, little endian
    lane = word >> (8 * addr[1:0]);
    r.rob_ix     = rob_ix;
    r.misaligned = 1'b0;
    r.data       = '0;
    case (op)
      load_path_pkg::LOP_LB:  r.data = {{24{lane[7]}}, lane[7:0]};
      load_path_pkg::LOP_LBU: r.data = {24'h0, lane[7:0]};
      load_path_pkg::LOP_LH: begin
        r.misaligned = addr[0];
        if (!addr[0]) begin
          r.data = {{16{lane[15]}}, lane[15:0]};
        end
      end
      load_path_pkg::LOP_LHU: begin
        r.misaligned = addr[0];
        if (!addr[0]) begin
          r.data = {16'h0, lane[15:0]};
        end
      end
      load_path_pkg::LOP_LW: begin
        r.misaligned = (addr[1:0] != 2'b00);
        if (addr[1:0] == 2'b00) begin
          r.data = word;
        end
      end
      default: r.data = word;
    endcase
    return r;
  endfunction

  // distance from the reorder head, modulo 8
  function automatic logic [2:0] rob_age(input logic [2:0] ix, input logic [2:0] head);
    logic [2:0] age;
    age = ix - head;
    return age;
  endfunction

  task automatic check_result(input load_path_pkg::load_result_t got);
    logic [2:0] ix;
    ix = got.rob_ix;
    if (!pending[ix]) begin
      $display("unexpected result for rob_ix %0d, no load outstanding with that index", ix);
      err_count++;
    end else begin
      if (got.data !== exp_res[ix].data) begin
        $display("FAILED result.data rob_ix=%0d: got %h expected %h",
                 ix, got.data, exp_res[ix].data);
        err_count++;
      end
      if (got.misaligned !== exp_res[ix].misaligned) begin
        $display("FAILED result.misaligned rob_ix=%0d: got %h expected %h",
                 ix, got.misaligned, exp_res[ix].misaligned);
        err_count++;
      end
      if (check_barrier && barrier_valid &&
          rob_age(ix, rob_head) >= rob_age(barrier_ix, rob_head)) begin
        $display("load rob_ix %0d completed while an older store barrier was held", ix);
        err_count++;
      end
      pending[ix] = 1'b0;
    end
  endtask

  // compare at the falling edge, all inputs and outputs settled
  always @(negedge clk_in) begin
    if (rst_n && !flush) begin
      if (prev_stalled) begin
        if (!result_valid) begin
          $display("FAILED result_valid while stalled: got %h expected %h", result_valid, 1'b1);
          err_count++;
        end else if (result !== prev_result) begin
          $display("FAILED result while stalled: got %h expected %h", result, prev_result);
          err_count++;
        end
      end
      // transfer happens on the coming rising edge
      if (result_valid && result_ready) begin
        check_result(result);
      end
      prev_stalled = result_valid && !result_ready;
      prev_result  = result;
    end else begin
      prev_stalled = 1'b0;
    end
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_in);
    $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_in);
    #1;
  endtask

  task automatic write_word(input int idx, input logic [31:0] data);
    mem_we    = 1'b1;
    mem_waddr = MA_W'(idx);
    mem_wdata = data;
    mem_model[idx] = data;
    @(posedge clk_in);
    #1;
    mem_we = 1'b0;
  endtask

  // one cycle offer; scoreboard entry only if taken
  task automatic offer_load(
    input  load_path_pkg::load_op_e op,
    input  logic [31:0]             base,
    input  logic [31:0]             offset,
    input  logic [2:0]              ix,
    output bit                      taken
  );
    req.op     = op;
    req.base   = base;
    req.offset = offset;
    req.rob_ix = ix;
    req_valid  = 1'b1;
    @(negedge clk_in);
    taken = req_ready;
    if (taken) begin
      exp_res[ix] = ref_load(op, base, offset, ix, mem_model);
      pending[ix] = 1'b1;
    end
    @(posedge clk_in);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic send_load(
    input load_path_pkg::load_op_e op,
    input logic [31:0]             base,
    input logic [31:0]             offset,
    input logic [2:0]              ix
  );
    bit taken;
    taken = 1'b0;
    while (!taken) begin
      offer_load(op, base, offset, ix, taken);
    end
  endtask

  // lowest index with no load in flight
  task automatic pick_free_ix(output logic [2:0] ix);
    while (&pending) begin
      @(posedge clk_in);
      #1;
    end
    ix = '0;
    for (int i = N_IX - 1; i >= 0; i--) begin
      if (!pending[i]) begin
        ix = 3'(i);
      end
    end
  endtask

  task automatic wait_drain();
    while (pending != '0) begin
      @(posedge clk_in);
      #1;
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (err_count == err_before) begin
      $display("test %s: ok", name);
      tests_ok++;
    end else begin
      $display("test %s: %0d errors", name, err_count - err_before);
      tests_bad++;
    end
  endtask

  initial begin
    int unsigned             seed_val;
    int                      e0;
    int                      sent;
    bit                      taken;
    bit                      have_load;
    logic [2:0]              ix;
    load_path_pkg::load_op_e op;
    logic [31:0]             base;
    logic [31:0]             offset;

    seed_val = $urandom(9);
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_model[i] = '0;
    end
    rst_n         = 1'b0;
    flush         = 1'b0;
    req           = '0;
    req_valid     = 1'b0;
    rob_head      = '0;
    barrier_valid = 1'b0;
    barrier_ix    = '0;
    result_ready  = 1'b1;
    mem_we        = 1'b0;
    mem_waddr     = '0;
    mem_wdata     = '0;

    repeat (8) @(posedge clk_in);
    #1;
    rst_n = 1'b1;

    // idle state right after reset
    e0 = err_count;
    @(negedge clk_in);
    if (req_ready !== 1'b1) begin
      $display("FAILED req_ready after reset: got %h expected %h", req_ready, 1'b1);
      err_count++;
    end
    if (result_valid !== 1'b0) begin
      $display("FAILED result_valid after reset: got %h expected %h", result_valid, 1'b0);
      err_count++;
    end
    @(posedge clk_in);
    #1;
    finish_test("reset", e0);

    // every opcode at every byte offset, negative offsets included
    e0 = err_count;
    write_word(4, 32'h80ff_7f01);
    write_word(5, 32'h1234_abcd);
    write_word(6, 32'hf00d_8765);
    write_word(7, 32'h7e80_01fe);
    for (int w = 0; w < 4; w++) begin
      for (int o = 0; o < 5; o++) begin
        for (int b = 0; b < 4; b++) begin
          pick_free_ix(ix);
          send_load(load_path_pkg::load_op_e'(3'(o)), 32'((w + 5) * 4), 32'(b - 4), ix);
        end
      end
    end
    wait_drain();
    finish_test("extension", e0);

    // odd halves, unaligned words, bytes anywhere
    // base 0x410 wraps onto word 4
    e0 = err_count;
    for (int b = 1; b < 4; b += 2) begin
      pick_free_ix(ix);
      send_load(load_path_pkg::LOP_LH, 32'h0000_0410, 32'(b), ix);
      pick_free_ix(ix);
      send_load(load_path_pkg::LOP_LHU, 32'h0000_0410, 32'(b), ix);
    end
    for (int b = 1; b < 4; b++) begin
      pick_free_ix(ix);
      send_load(load_path_pkg::LOP_LW, 32'h0000_0414, 32'(b), ix);
    end
    for (int b = 0; b < 4; b++) begin
      pick_free_ix(ix);
      send_load(load_path_pkg::LOP_LB, 32'h0000_0418, 32'(b), ix);
    end
    wait_drain();
    finish_test("misalignment", e0);

    // head at 6, store at 1: 6 7 0 older, 2 3 4 younger
    e0 = err_count;
    rob_head      = 3'd6;
    barrier_ix    = 3'd1;
    barrier_valid = 1'b1;
    check_barrier = 1'b1;
    send_load(load_path_pkg::LOP_LW,  32'h0000_0010, 32'h0, 3'd2);
    send_load(load_path_pkg::LOP_LB,  32'h0000_0014, 32'h3, 3'd6);
    send_load(load_path_pkg::LOP_LHU, 32'h0000_0018, 32'h2, 3'd3);
    send_load(load_path_pkg::LOP_LH,  32'h0000_001c, 32'h0, 3'd7);
    send_load(load_path_pkg::LOP_LBU, 32'h0000_0010, 32'h1, 3'd4);
    send_load(load_path_pkg::LOP_LW,  32'h0000_0018, 32'h0, 3'd0);
    // older loads 6 7 0 drain past the store
    while ((pending & 8'b1100_0001) != '0) begin
      @(posedge clk_in);
      #1;
    end
    // younger ones get time to leak if the ordering check is broken
    wait_cycles(20);
    if (pending !== 8'b0001_1100) begin
      $display("FAILED pending loads behind barrier: got %h expected %h", pending, 8'h1c);
      err_count++;
    end
    barrier_valid = 1'b0;
    check_barrier = 1'b0;
    wait_drain();
    rob_head = '0;
    finish_test("barrier", e0);

    // stall results until the request side backs up
    e0 = err_count;
    result_ready = 1'b0;
    sent  = 0;
    taken = 1'b1;
    while (taken && sent < N_BP) begin
      offer_load(load_path_pkg::load_op_e'(3'(sent % 5)), 32'h0000_0010,
                 32'(4 * (sent % 4)), 3'(sent), taken);
      if (taken) begin
        sent++;
      end
    end
    if (taken) begin
      $display("req_ready never fell with %0d loads held under back-pressure", sent);
      err_count++;
    end
    wait_cycles(10);
    result_ready = 1'b1;
    wait_drain();
    finish_test("backpressure", e0);

    // everything blocked, buffer filled, then flushed away
    e0 = err_count;
    rob_head      = 3'd0;
    barrier_ix    = 3'd0;
    barrier_valid = 1'b1;
    for (int i = 1; i <= 4; i++) begin
      send_load(load_path_pkg::LOP_LW, 32'(16 + 4 * (i % 4)), 32'h0, 3'(i));
    end
    wait_cycles(5);
    flush   = 1'b1;
    pending = '0;
    wait_cycles(1);
    flush         = 1'b0;
    barrier_valid = 1'b0;
    // any result here comes from a flushed load
    wait_cycles(20);
    for (int i = 4; i < 8; i++) begin
      send_load(load_path_pkg::LOP_LH, 32'h0000_0010, 32'(2 * i), 3'(i));
    end
    wait_drain();
    finish_test("flush", e0);

    // random memory, loads, barrier and result_ready
    e0 = err_count;
    for (int i = 0; i < MEM_WORDS; i++) begin
      write_word(i, $urandom);
    end
    sent      = 0;
    have_load = 1'b0;
    while (sent < N_RAND) begin
      result_ready = ($urandom_range(0, 3) != 0);
      if ($urandom_range(0, 7) == 0) begin
        barrier_valid = !barrier_valid;
        barrier_ix    = 3'($urandom_range(0, 7));
      end
      if (!have_load && !(&pending)) begin
        ix = 3'($urandom_range(0, 7));
        while (pending[ix]) begin
          ix = 3'($urandom_range(0, 7));
        end
        op        = load_path_pkg::load_op_e'(3'($urandom_range(0, 4)));
        base      = $urandom;
        offset    = $urandom;
        have_load = 1'b1;
      end
      if (have_load) begin
        // same load offered again until taken
        offer_load(op, base, offset, ix, taken);
        if (taken) begin
          sent++;
          have_load = 1'b0;
        end
      end else begin
        wait_cycles(1);
      end
    end
    result_ready  = 1'b1;
    barrier_valid = 1'b0;
    wait_drain();
    finish_test("random", e0);

    wait_cycles(5);
    $display("tests passed %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, err_count);
    if (err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: load_path.f
design/load_path_pkg.sv
design/load_addr_gen.sv
design/load_buffer.sv
design/load_order_check.sv
design/load_mem_unit.sv
design/load_path_top.sv
verification/load_path_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the load path testbench with Verilator, run it, grade the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module load_path_tb -f load_path.f -o load_path_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/load_path_sim > sim.log 2>&1
cat sim.log

grep -qx "TESTBENCH PASSED" sim.log && echo "simulation passed" && exit 0 \
  || { echo "simulation failed, see sim.log"; exit 1; }
